// File: common/mips_pkg.sv
`default_nettype none

// shared types for the ex/mem half of the pipeline
package mips_pkg;

    // data path word
    typedef logic [31:0] word_t;

    // register file index, 32 entries
    typedef logic [4:0] reg_addr_t;

    // alu function, same coding as the r-type funct field
    typedef logic [5:0] alu_op_t;

    // funct codes understood by the execute stage
    localparam alu_op_t alu_add = 6'h20;
    localparam alu_op_t alu_sub = 6'h22;
    localparam alu_op_t alu_and = 6'h24;
    localparam alu_op_t alu_or  = 6'h25;
    localparam alu_op_t alu_xor = 6'h26;
    localparam alu_op_t alu_nor = 6'h27;
    // signed set-less-than
    localparam alu_op_t alu_slt = 6'h2a;

    // any other code gives a zero result

endpackage

`default_nettype wire

// File: hw/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

// execute stage
// purely combinational, the ex/mem register sits right after it
module alu_exec (
    input  wire logic                clk,
    input  wire logic                reset,

    // decoded operation
    input  wire mips_pkg::word_t     operand_a,
    input  wire mips_pkg::word_t     operand_b,
    input  wire mips_pkg::word_t     store_data,
    input  wire mips_pkg::reg_addr_t dest,
    input  wire mips_pkg::alu_op_t   alu_op,

    // control bits from decode
    input  wire logic                regwrite,
    input  wire logic                memwrite,
    input  wire logic                memread,
    input  wire logic                memtoreg,

    // towards ex/mem
    output mips_pkg::word_t          alu_result,
    output mips_pkg::word_t          read_data2,
    output mips_pkg::reg_addr_t      regdst,
    output logic                     regwrite_out,
    output logic                     memwrite_out,
    output logic                     memread_out,
    output logic                     memtoreg_out,
    output mips_pkg::alu_op_t        alu_op_out
);
    import mips_pkg::*;

    // signed compare for slt
    logic slt_bit;

    assign slt_bit = $signed(operand_a) < $signed(operand_b);

    // function decode
    always_comb begin
        case (alu_op)
            alu_add: alu_result = operand_a + operand_b;
            alu_sub: alu_result = operand_a - operand_b;
            alu_and: alu_result = operand_a & operand_b;
            alu_or:  alu_result = operand_a | operand_b;
            alu_xor: alu_result = operand_a ^ operand_b;
            alu_nor: alu_result = ~(operand_a | operand_b);
            // zero-extended compare flag
            alu_slt: alu_result = {31'b0, slt_bit};
            default: alu_result = '0;
        endcase
    end

    // store data rides along for the memory stage
    assign read_data2   = store_data;
    assign regdst       = dest;

    // control passes straight through
    assign regwrite_out = regwrite;
    assign memwrite_out = memwrite;
    assign memread_out  = memread;
    assign memtoreg_out = memtoreg;
    assign alu_op_out   = alu_op;

    // decode never issues a load and a store in the same slot
    a_no_load_store: assert property (
        @(posedge clk) disable iff (reset)
        !(memwrite && memread)
    ) else $error("alu_exec: memwrite and memread both set");

endmodule

`default_nettype wire

// File: hw/ex_mem.sv
`timescale 1ns/1ps
`default_nettype none

// ex/mem pipeline register
// copies every field on each rising edge, no stall
module ex_mem (
    input  wire logic                clk,
    input  wire logic                reset,

    // data fields from execute
    input  wire mips_pkg::word_t     alu_result,
    // store data
    input  wire mips_pkg::word_t     read_data2,
    // write register
    input  wire mips_pkg::reg_addr_t regdst,

    // control fields from execute
    input  wire logic                regwrite,
    input  wire logic                memwrite,
    input  wire logic                memread,
    input  wire logic                memtoreg,
    input  wire mips_pkg::alu_op_t   alu_op,

    // registered data fields
    output mips_pkg::word_t          alu_result_out,
    output mips_pkg::word_t          read_data2_out,
    output mips_pkg::reg_addr_t      regdst_out,

    // registered control fields
    output logic                     regwrite_out,
    output logic                     memwrite_out,
    output logic                     memread_out,
    output logic                     memtoreg_out,
    output mips_pkg::alu_op_t        alu_op_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            // data fields
            alu_result_out <= '0;
            read_data2_out <= '0;
            regdst_out     <= '0;
            // control fields, no memory access after reset
            regwrite_out   <= 1'b0;
            memwrite_out   <= 1'b0;
            memread_out    <= 1'b0;
            memtoreg_out   <= 1'b0;
            alu_op_out     <= '0;
        end else begin
            alu_result_out <= alu_result;
            read_data2_out <= read_data2;
            regdst_out     <= regdst;
            regwrite_out   <= regwrite;
            memwrite_out   <= memwrite;
            memread_out    <= memread;
            memtoreg_out   <= memtoreg;
            // kept only so the funct code shows up next to the op in waves
            alu_op_out     <= alu_op;
        end
    end

endmodule

`default_nettype wire

// File: mem_stage/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

// word-addressed data memory
// async read, write on rising edge
module data_mem #(
    parameter int mem_words = 256
) (
    input  wire logic            clk,
    // byte address, low two bits ignored
    input  wire mips_pkg::word_t addr,
    input  wire mips_pkg::word_t write_data,
    input  wire logic            write_en,
    output mips_pkg::word_t      read_data
);
    import mips_pkg::*;

    // index width, at least one bit
    localparam int addr_w = (mem_words > 1) ? $clog2(mem_words) : 1;

    // storage, contents survive reset
    word_t mem [mem_words];

    // word index
    logic [addr_w-1:0] word_index;
    // byte address shifted down to words
    word_t             word_addr;

    assign word_addr = addr >> 2;

    // high addresses alias back into the array
    assign word_index = addr_w'(word_addr % mem_words);

    // combinational read, so a load right after a store
    // sees the value written on the previous edge
    assign read_data = mem[word_index];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[word_index] <= write_data;
        end
    end

    // stores are full words only
    a_write_aligned: assert property (
        @(posedge clk)
        write_en |-> (addr[1:0] == 2'b00)
    ) else $error("data_mem: unaligned write address %h", addr);

endmodule

`default_nettype wire

// File: mem_stage/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

// memory stage plus the mem/wb register
module mem_access #(
    parameter int mem_words = 256
) (
    input  wire logic                clk,
    input  wire logic                reset,

    // from ex/mem
    input  wire mips_pkg::word_t     alu_result_out,
    input  wire mips_pkg::word_t     read_data2_out,
    input  wire mips_pkg::reg_addr_t regdst_out,
    input  wire logic                regwrite_out,
    input  wire logic                memwrite_out,
    input  wire logic                memread_out,
    input  wire logic                memtoreg_out,

    // writeback triple
    output logic                     wb_regwrite,
    output mips_pkg::reg_addr_t      wb_dest,
    output mips_pkg::word_t          wb_data
);
    import mips_pkg::*;

    // load data back from the memory
    word_t load_data;
    // value headed for the register file
    word_t mem_stage_data;

    // alu result doubles as the byte address
    // store data comes from register rt
    data_mem #(
        .mem_words  (mem_words)
    ) data_mem0 (
        .clk        (clk),
        .addr       (alu_result_out),
        .write_data (read_data2_out),
        .write_en   (memwrite_out),
        .read_data  (load_data)
    );

    // memtoreg picks the loaded word over the alu result
    assign mem_stage_data = memtoreg_out ? load_data : alu_result_out;

    // mem/wb register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_regwrite <= 1'b0;
            wb_dest     <= '0;
            wb_data     <= '0;
        end else begin
            wb_regwrite <= regwrite_out;
            wb_dest     <= regdst_out;
            wb_data     <= mem_stage_data;
        end
    end

    // load data is only meaningful when decode asked for a read
    a_memtoreg_read: assert property (
        @(posedge clk) disable iff (reset)
        memtoreg_out |-> memread_out
    ) else $error("mem_access: memtoreg without memread");

endmodule

`default_nettype wire

// File: hw/exmem_top.sv
`timescale 1ns/1ps
`default_nettype none

// execute -> ex/mem -> memory stage, two cycles to writeback
module exmem_top #(
    parameter int mem_words = 256
) (
    input  wire logic                clk,
    input  wire logic                reset,

    // decoded operation
    input  wire mips_pkg::word_t     operand_a,
    input  wire mips_pkg::word_t     operand_b,
    input  wire mips_pkg::word_t     store_data,
    input  wire mips_pkg::reg_addr_t dest,
    input  wire mips_pkg::alu_op_t   alu_op,
    input  wire logic                regwrite,
    input  wire logic                memwrite,
    input  wire logic                memread,
    input  wire logic                memtoreg,

    // writeback
    output logic                     wb_regwrite,
    output mips_pkg::reg_addr_t      wb_dest,
    output mips_pkg::word_t          wb_data
);
    import mips_pkg::*;

    // execute stage outputs
    word_t     ex_alu_result;
    word_t     ex_read_data2;
    reg_addr_t ex_regdst;
    logic      ex_regwrite;
    logic      ex_memwrite;
    logic      ex_memread;
    logic      ex_memtoreg;
    alu_op_t   ex_alu_op;

    // ex/mem register outputs
    word_t     mem_alu_result;
    word_t     mem_read_data2;
    reg_addr_t mem_regdst;
    logic      mem_regwrite;
    logic      mem_memwrite;
    logic      mem_memread;
    logic      mem_memtoreg;
    // debug only, not consumed downstream
    alu_op_t   mem_alu_op;

    alu_exec alu_exec0 (
        .clk          (clk),
        .reset        (reset),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .store_data   (store_data),
        .dest         (dest),
        .alu_op       (alu_op),
        .regwrite     (regwrite),
        .memwrite     (memwrite),
        .memread      (memread),
        .memtoreg     (memtoreg),
        .alu_result   (ex_alu_result),
        .read_data2   (ex_read_data2),
        .regdst       (ex_regdst),
        .regwrite_out (ex_regwrite),
        .memwrite_out (ex_memwrite),
        .memread_out  (ex_memread),
        .memtoreg_out (ex_memtoreg),
        .alu_op_out   (ex_alu_op)
    );

    ex_mem ex_mem0 (
        .clk            (clk),
        .reset          (reset),
        .alu_result     (ex_alu_result),
        .read_data2     (ex_read_data2),
        .regdst         (ex_regdst),
        .regwrite       (ex_regwrite),
        .memwrite       (ex_memwrite),
        .memread        (ex_memread),
        .memtoreg       (ex_memtoreg),
        .alu_op         (ex_alu_op),
        .alu_result_out (mem_alu_result),
        .read_data2_out (mem_read_data2),
        .regdst_out     (mem_regdst),
        .regwrite_out   (mem_regwrite),
        .memwrite_out   (mem_memwrite),
        .memread_out    (mem_memread),
        .memtoreg_out   (mem_memtoreg),
        .alu_op_out     (mem_alu_op)
    );

    mem_access #(
        .mem_words      (mem_words)
    ) mem_access0 (
        .clk            (clk),
        .reset          (reset),
        .alu_result_out (mem_alu_result),
        .read_data2_out (mem_read_data2),
        .regdst_out     (mem_regdst),
        .regwrite_out   (mem_regwrite),
        .memwrite_out   (mem_memwrite),
        .memread_out    (mem_memread),
        .memtoreg_out   (mem_memtoreg),
        .wb_regwrite    (wb_regwrite),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data)
    );

endmodule

`default_nettype wire

// File: bench/tb_exmem.sv
`timescale 1ns/1ps
`default_nettype none

// random stimulus into exmem_top with every writeback checked against a model
module tb_exmem;
    import mips_pkg::*;

    localparam int mem_words = 256;
    // byte span of the whole array and so the alias step
    localparam word_t mem_span = mem_words * 4;

    // one expected writeback
    typedef struct packed {
        logic      regwrite;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

    logic      clk;
    logic      reset;
    word_t     operand_a;
    word_t     operand_b;
    word_t     store_data;
    reg_addr_t dest;
    alu_op_t   alu_op;
    logic      regwrite;
    logic      memwrite;
    logic      memread;
    logic      memtoreg;
    logic      wb_regwrite;
    reg_addr_t wb_dest;
    word_t     wb_data;

    // model memory and the ops still in flight
    word_t  model_mem [mem_words];
    wb_t    exp_q [$];
    integer seed;
    int     flag_errs;
    int     dest_errs;
    int     data_errs;
    logic   timed_out;

    exmem_top #(
        .mem_words   (mem_words)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .store_data  (store_data),
        .dest        (dest),
        .alu_op      (alu_op),
        .regwrite    (regwrite),
        .memwrite    (memwrite),
        .memread     (memread),
        .memtoreg    (memtoreg),
        .wb_regwrite (wb_regwrite),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t rand_word();
        word_t v;
        v = $random(seed);
        return v;
    endfunction

    // word-aligned base anywhere in the address space
    function automatic word_t aligned_word();
        word_t r;
        r = rand_word();
        return {r[31:2], 2'b00};
    endfunction

    // small aligned offset up to 252
    function automatic word_t small_offset();
        word_t r;
        r = rand_word();
        return {24'b0, r[7:2], 2'b00};
    endfunction

    // r-type funct semantics with a signed slt
    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            6'h20: return a + b;
            6'h22: return a - b;
            6'h24: return a & b;
            6'h25: return a | b;
            6'h26: return a ^ b;
            6'h27: return ~(a | b);
            6'h2a: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    // word index wrapping modulo the depth
    function automatic int mem_index(word_t addr);
        return int'((addr >> 2) % mem_words);
    endfunction

    task automatic check_wb_flag(logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED @%0t: wb_regwrite got %b expected %b", $time, got, exp);
            flag_errs++;
        end
    endtask

    task automatic check_wb_dest(reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED @%0t: wb_dest got %0d expected %0d", $time, got, exp);
            dest_errs++;
        end
    endtask

    task automatic check_wb_data(word_t got, word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED @%0t: wb_data got %h expected %h", $time, got, exp);
            data_errs++;
        end
    endtask

    // oldest op in flight against the writeback ports
    task automatic compare_front();
        wb_t e;
        e = exp_q.pop_front();
        check_wb_flag(wb_regwrite, e.regwrite);
        check_wb_dest(wb_dest, e.dest);
        check_wb_data(wb_data, e.data);
    endtask

    // entered on a falling edge and returns on the next one
    task automatic apply_op(word_t a, word_t b, word_t sd, reg_addr_t d, alu_op_t op,
                            logic rw, logic mw, logic mr, logic mtr);
        wb_t   e;
        word_t res;
        // op applied two falling edges back has reached writeback
        if (exp_q.size() == 2)
            compare_front();
        operand_a  = a;
        operand_b  = b;
        store_data = sd;
        dest       = d;
        alu_op     = op;
        regwrite   = rw;
        memwrite   = mw;
        memread    = mr;
        memtoreg   = mtr;
        // model runs in program order so a load sees every earlier store
        res        = model_alu(op, a, b);
        e.regwrite = rw;
        e.dest     = d;
        e.data     = mtr ? model_mem[mem_index(res)] : res;
        if (mw)
            model_mem[mem_index(res)] = sd;
        exp_q.push_back(e);
        @(negedge clk);
    endtask

    task automatic random_alu();
        word_t   r;
        alu_op_t op;
        r = rand_word();
        case (r[2:0])
            3'd0: op = 6'h20;
            3'd1: op = 6'h22;
            3'd2: op = 6'h24;
            3'd3: op = 6'h25;
            3'd4: op = 6'h26;
            3'd5: op = 6'h27;
            3'd6: op = 6'h2a;
            // bit 5 clear so never a listed code
            default: op = {1'b0, r[7:3]};
        endcase
        apply_op(rand_word(), rand_word(), rand_word(), r[12:8], op,
                 r[13], 1'b0, 1'b0, 1'b0);
    endtask

    task automatic store_word(word_t a, word_t b, word_t data);
        word_t r;
        r = rand_word();
        apply_op(a, b, data, r[4:0], 6'h20, 1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic load_word(word_t a, word_t b);
        word_t r;
        r = rand_word();
        apply_op(a, b, rand_word(), r[4:0], 6'h20, 1'b1, 1'b0, 1'b1, 1'b1);
    endtask

    // idle inputs and then collect the last two writebacks
    task automatic drain_queue();
        int waited;
        waited   = 0;
        regwrite = 1'b0;
        memwrite = 1'b0;
        memread  = 1'b0;
        memtoreg = 1'b0;
        alu_op   = '0;
        while (exp_q.size() > 0 && waited < 8) begin
            compare_front();
            @(negedge clk);
            waited++;
        end
        timed_out = (exp_q.size() > 0);
    endtask

    initial begin
        word_t a;
        word_t b;
        word_t d;
        word_t alias_addr;
        int    i;
        seed       = 32'h372d_7b3f;
        flag_errs  = 0;
        dest_errs  = 0;
        data_errs  = 0;
        timed_out  = 1'b0;
        reset      = 1'b1;
        // a live register write held under reset never reaches writeback
        operand_a  = rand_word();
        operand_b  = rand_word();
        store_data = rand_word();
        dest       = 5'd17;
        alu_op     = 6'h20;
        regwrite   = 1'b1;
        memwrite   = 1'b0;
        memread    = 1'b0;
        memtoreg   = 1'b0;

        // 16 rising edges under reset
        for (i = 0; i < 16; i++)
            @(negedge clk);
        reset      = 1'b0;
        // idle inputs from release on
        operand_a  = '0;
        operand_b  = '0;
        store_data = '0;
        dest       = '0;
        alu_op     = '0;
        regwrite   = 1'b0;
        @(negedge clk);

        // nothing applied yet so writeback stays cleared
        check_wb_flag(wb_regwrite, 1'b0);
        check_wb_dest(wb_dest, '0);
        check_wb_data(wb_data, '0);

        // every word gets an address-derived value first
        for (i = 0; i < mem_words; i++) begin
            a = word_t'(i) << 2;
            store_word(a, 32'd0, {16'h5a3c ^ a[15:0], ~a[15:0]});
        end

        // all seven codes plus unlisted ones
        for (i = 0; i < 200; i++)
            random_alu();

        // store then some alu work then a load of the same base + offset
        for (i = 0; i < 40; i++) begin
            a = aligned_word();
            b = small_offset();
            store_word(a, b, rand_word());
            random_alu();
            random_alu();
            load_word(a, b);
        end

        // load right behind the store
        for (i = 0; i < 40; i++) begin
            a = aligned_word();
            b = small_offset();
            store_word(a, b, rand_word());
            load_word(a, b);
        end

        // store above the array and read back through the wrapped alias
        for (i = 0; i < 20; i++) begin
            d          = rand_word();
            a          = word_t'(mem_index(d)) << 2;
            alias_addr = a + ({28'b0, d[11:8]} + 32'd1) * mem_span;
            store_word(alias_addr, 32'd0, rand_word());
            random_alu();
            load_word(a, 32'd0);
        end

        // mixed traffic with one op per cycle
        for (i = 0; i < 300; i++) begin
            d = rand_word();
            case (d[1:0])
                2'd0: store_word(aligned_word(), small_offset(), rand_word());
                2'd1: load_word(aligned_word(), small_offset());
                default: random_alu();
            endcase
        end

        drain_queue();

        if (timed_out) begin
            $display("timeout: %0d writebacks never arrived", exp_q.size());
            $display(">>> FAIL");
            $finish;
        end else begin
            $display("errors: %0d regwrite, %0d dest, %0d data",
                     flag_errs, dest_errs, data_errs);
            if (flag_errs + dest_errs + data_errs == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
common/mips_pkg.sv
hw/alu_exec.sv
hw/ex_mem.sv
mem_stage/data_mem.sv
mem_stage/mem_access.sv
hw/exmem_top.sv
bench/tb_exmem.sv

// File: run.sh
#!/bin/sh
# build and run the ex/mem bench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module tb_exmem -o tb_exmem_sim

out=$(./obj_dir/tb_exmem_sim)
echo "$out"

if echo "$out" | grep -qxF '>>> PASS'; then
    exit 0
else
    exit 1
fi
